// ==== files.f ====
+incdir+.
mips_pkg.sv
mips_pipe_reg.sv
mips_fetch.sv
mips_decode.sv
mips_regfile.sv
mips_execute.sv
mips_hazard.sv
mips.sv
tb_mips.sv

// ==== Makefile ====
# Verilator build and run for the five-stage MIPS core

VERILATOR ?= verilator
TOP       ?= tb_mips
LINT_TOP  ?= mips
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF -- "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_mips.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module tb_mips;

	localparam int MAX_CYCLES = 400;
	// Enough edges for the last store to leave the pipeline behind two stall cycles
	localparam int DRAIN_CYCLES = 8;

	logic        clk;
	logic        rst_n;
	logic [31:0] im_dout;
	logic [31:0] dm_rdata;
	logic [29:0] im_addr;
	logic [29:0] dm_addr;
	logic [31:0] dm_wdata;
	logic        dm_we;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] prog [$];
	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          tests;

	mips dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.im_dout  (im_dout),
		.dm_rdata (dm_rdata),
		.im_addr  (im_addr),
		.dm_addr  (dm_addr),
		.dm_wdata (dm_wdata),
		.dm_we    (dm_we)
	);

	always #50 clk = ~clk;

	// Both memories answer in the same cycle
	assign im_dout  = imem[im_addr[7:0]];
	assign dm_rdata = dmem[dm_addr[7:0]];

	always @(posedge clk) begin
		if (dm_we) begin
			dmem[dm_addr[7:0]] <= dm_wdata;
		end
	end

	function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {`MIPS_OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] j_type(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	function automatic logic [31:0] dmem_fill(input int idx);
		return 32'hd00d_0000 | idx;
	endfunction

	// Galois form, taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		value_ok: assert (got === exp) else begin
			$display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic emit(input logic [31:0] instr);
		prog.push_back(instr);
	endtask

	// Unused words hold addiu $0 with the word's own address
	task automatic fill_memories();
		for (int i = 0; i < 256; i++) begin
			imem[i] = i_type(`MIPS_OP_ADDIU, 5'd0, 5'd0, i[15:0]);
			dmem[i] <= dmem_fill(i);
		end
	endtask

	task automatic begin_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		fill_memories();
	endtask

	// Appends the end loop, releases reset and waits for the core to reach it
	task automatic run_program();
		int  self_idx;
		int  cycles;
		bit  reached;
		self_idx = prog.size();
		prog.push_back(j_type(`MIPS_OP_J, 26'(self_idx)));
		prog.push_back(32'h0000_0000);
		for (int i = 0; i < prog.size(); i++) begin
			imem[i] = prog[i];
		end
		prog.delete();
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		cycles = 0;
		reached = 1'b0;
		while (!reached && cycles < MAX_CYCLES) begin
			@(negedge clk);
			reached = (im_addr == 30'(self_idx));
			cycles++;
		end
		if (!reached) begin
			$display("timeout: fetch never reached the end loop at word %0d in %0d cycles",
				self_idx, MAX_CYCLES);
			errors++;
		end else begin
			repeat (DRAIN_CYCLES) @(negedge clk);
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		tests++;
		if (errors == err0) begin
			$display("test %-10s ok", name);
		end else begin
			$display("test %-10s bad, %0d errors", name, errors - err0);
		end
	endtask

	task automatic check_reset_state();
		int err0;
		err0 = errors;
		begin_reset();
		@(negedge clk);
		check_word("dm_we", {31'b0, dm_we}, 32'h0);
		check_word("im_addr", {2'b00, im_addr}, {2'b00, `MIPS_RESET_PC});
		run_program();
		finish_test("reset", err0);
	endtask

	task automatic check_alu_chain();
		int          err0;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sh;
		logic [31:0] i1;
		logic [31:0] i2;
		logic [31:0] i3;
		logic [31:0] exp [10];
		err0 = errors;
		rand_bits(32, a);
		rand_bits(32, b);
		rand_bits(5, sh);
		rand_bits(16, i1);
		rand_bits(16, i2);
		rand_bits(16, i3);
		exp[0] = a + b;
		exp[1] = exp[0] - a;
		exp[2] = exp[1] & exp[0];
		exp[3] = exp[2] | b;
		exp[4] = exp[3] ^ exp[1];
		exp[5] = ($signed(exp[4]) < $signed(a)) ? 32'd1 : 32'd0;
		exp[6] = exp[4] << sh[4:0];
		exp[7] = exp[6] + {{16{i1[15]}}, i1[15:0]};
		exp[8] = exp[7] | {16'h0000, i2[15:0]};
		exp[9] = {i3[15:0], 16'h0000};
		begin_reset();
		emit(i_type(`MIPS_OP_LUI, 5'd0, 5'd1, a[31:16]));
		emit(i_type(`MIPS_OP_ORI, 5'd1, 5'd1, a[15:0]));
		emit(i_type(`MIPS_OP_LUI, 5'd0, 5'd2, b[31:16]));
		emit(i_type(`MIPS_OP_ORI, 5'd2, 5'd2, b[15:0]));
		emit(r_type(`MIPS_FN_ADDU, 5'd1, 5'd2, 5'd3, 5'd0));
		emit(r_type(`MIPS_FN_SUBU, 5'd3, 5'd1, 5'd4, 5'd0));
		emit(r_type(`MIPS_FN_AND, 5'd4, 5'd3, 5'd5, 5'd0));
		emit(r_type(`MIPS_FN_OR, 5'd5, 5'd2, 5'd6, 5'd0));
		emit(r_type(`MIPS_FN_XOR, 5'd6, 5'd4, 5'd7, 5'd0));
		emit(r_type(`MIPS_FN_SLT, 5'd7, 5'd1, 5'd8, 5'd0));
		emit(r_type(`MIPS_FN_SLL, 5'd0, 5'd7, 5'd9, sh[4:0]));
		emit(i_type(`MIPS_OP_ADDIU, 5'd9, 5'd10, i1[15:0]));
		emit(i_type(`MIPS_OP_ORI, 5'd10, 5'd11, i2[15:0]));
		emit(i_type(`MIPS_OP_LUI, 5'd0, 5'd12, i3[15:0]));
		for (int k = 0; k < 10; k++) begin
			emit(i_type(`MIPS_OP_SW, 5'd0, 5'(3 + k), 16'(16'h0100 + 4 * k)));
		end
		run_program();
		for (int k = 0; k < 10; k++) begin
			check_word($sformatf("dmem[%0d]", 64 + k), dmem[64 + k], exp[k]);
		end
		finish_test("alu_chain", err0);
	endtask

	task automatic check_load_use();
		int          err0;
		logic [31:0] v;
		logic [31:0] w;
		logic [31:0] add;
		logic [31:0] sum;
		err0 = errors;
		rand_bits(32, v);
		rand_bits(32, w);
		rand_bits(16, add);
		sum = v + {{16{add[15]}}, add[15:0]};
		begin_reset();
		dmem[16] <= v;
		dmem[17] <= w;
		emit(i_type(`MIPS_OP_LW, 5'd0, 5'd1, 16'h0040));
		emit(i_type(`MIPS_OP_ADDIU, 5'd1, 5'd2, add[15:0]));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd2, 16'h0080));
		emit(i_type(`MIPS_OP_LW, 5'd0, 5'd3, 16'h0044));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd3, 16'h0084));
		emit(i_type(`MIPS_OP_LW, 5'd0, 5'd4, 16'h0044));
		emit(r_type(`MIPS_FN_ADDU, 5'd2, 5'd4, 5'd5, 5'd0));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd5, 16'h0088));
		run_program();
		check_word("dmem[32]", dmem[32], sum);
		check_word("dmem[33]", dmem[33], w);
		check_word("dmem[34]", dmem[34], sum + w);
		finish_test("load_use", err0);
	endtask

	task automatic check_branches();
		int         err0;
		logic [9:0] written;
		err0 = errors;
		// Marker slots at words 64 to 73, bit k set where the store must land
		written = 10'b01_1111_0101;
		begin_reset();
		dmem[16] <= 32'd5;
		emit(i_type(`MIPS_OP_ADDIU, 5'd0, 5'd1, 16'd5));
		emit(i_type(`MIPS_OP_ADDIU, 5'd0, 5'd2, 16'd5));
		emit(i_type(`MIPS_OP_ADDIU, 5'd0, 5'd9, 16'd1));
		emit(i_type(`MIPS_OP_BEQ, 5'd1, 5'd2, 16'd2));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0100));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0104));
		// Producer right before bne
		emit(i_type(`MIPS_OP_ADDIU, 5'd0, 5'd3, 16'd7));
		emit(i_type(`MIPS_OP_BNE, 5'd3, 5'd0, 16'd2));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0108));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h010c));
		emit(i_type(`MIPS_OP_BEQ, 5'd1, 5'd3, 16'd2));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0110));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0114));
		// Load feeding a branch
		emit(i_type(`MIPS_OP_LW, 5'd0, 5'd4, 16'h0040));
		emit(i_type(`MIPS_OP_BNE, 5'd4, 5'd1, 16'd2));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0118));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h011c));
		emit(i_type(`MIPS_OP_BEQ, 5'd4, 5'd2, 16'd2));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0120));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd9, 16'h0124));
		run_program();
		for (int k = 0; k < 10; k++) begin
			check_word($sformatf("dmem[%0d]", 64 + k), dmem[64 + k],
				written[k] ? 32'd1 : dmem_fill(64 + k));
		end
		finish_test("branches", err0);
	endtask

	task automatic check_jal_jr();
		int err0;
		int jal_idx;
		err0 = errors;
		jal_idx = 0;
		begin_reset();
		emit(j_type(`MIPS_OP_JAL, 26'd6));
		emit(i_type(`MIPS_OP_ADDIU, 5'd0, 5'd5, 16'd3));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd31, 16'h0100));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd6, 16'h0104));
		emit(j_type(`MIPS_OP_J, 26'd9));
		emit(32'h0000_0000);
		// Subroutine
		emit(i_type(`MIPS_OP_ADDIU, 5'd0, 5'd6, 16'h0077));
		emit(r_type(`MIPS_FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
		emit(i_type(`MIPS_OP_SW, 5'd0, 5'd5, 16'h0108));
		run_program();
		check_word("dmem[64]", dmem[64], 32'(jal_idx * 4 + 8));
		check_word("dmem[65]", dmem[65], 32'h0000_0077);
		check_word("dmem[66]", dmem[66], 32'd3);
		finish_test("jal_jr", err0);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		lfsr = 32'hbcd6;
		errors = 0;
		checks = 0;
		tests = 0;
		fill_memories();
		check_alu_chain();
		// Reset from a running core, with the PC away from the reset address
		check_reset_state();
		check_load_use();
		check_branches();
		check_jal_jr();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== mips.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire mips_pkg::word_t im_dout,
	input  wire mips_pkg::word_t dm_rdata,
	output mips_pkg::pc_t        im_addr,
	output mips_pkg::pc_t        dm_addr,
	output mips_pkg::word_t      dm_wdata,
	output logic                 dm_we
);

	mips_pkg::pc_t      pc;
	mips_pkg::pc_t      pc_plus1;
	mips_pkg::pc_t      branch_target;
	logic               branch_taken;
	logic               stall;
	mips_pkg::if_id_t   if_id_d;
	mips_pkg::if_id_t   if_id_q;
	mips_pkg::id_ex_t   id_ex_d;
	mips_pkg::id_ex_t   id_ex_q;
	mips_pkg::ex_mem_t  ex_mem_d;
	mips_pkg::ex_mem_t  ex_mem_q;
	mips_pkg::mem_wb_t  mem_wb_d;
	mips_pkg::mem_wb_t  mem_wb_q;
	mips_pkg::reg_idx_t dec_rs;
	mips_pkg::reg_idx_t dec_rt;
	mips_pkg::ctrl_t    dec_ctrl;
	mips_pkg::word_t    dec_imm;
	mips_pkg::word_t    rf_rs_val;
	mips_pkg::word_t    rf_rt_val;
	mips_pkg::fwd_sel_t fwd_cmp_a;
	mips_pkg::fwd_sel_t fwd_cmp_b;
	mips_pkg::fwd_sel_t fwd_alu_a;
	mips_pkg::fwd_sel_t fwd_alu_b;
	logic               fwd_store;
	mips_pkg::word_t    m_fwd;
	logic               wb_we;
	mips_pkg::reg_idx_t wb_idx;
	mips_pkg::word_t    wb_data;

	mips_fetch fetch_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.pc            (pc),
		.pc_plus1      (pc_plus1)
	);

	assign im_addr = pc;
	assign if_id_d = '{instr: im_dout, pc_plus4: pc_plus1};

	mips_pipe_reg #(.payload_t(mips_pkg::if_id_t)) if_id_i (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (!stall),
		.clear (1'b0),
		.d     (if_id_d),
		.q     (if_id_q)
	);

	mips_decode decode_i (
		.if_id         (if_id_q),
		.rs_val        (rf_rs_val),
		.rt_val        (rf_rt_val),
		.m_fwd         (m_fwd),
		.w_fwd         (wb_data),
		.fwd_cmp_a     (fwd_cmp_a),
		.fwd_cmp_b     (fwd_cmp_b),
		.rs            (dec_rs),
		.rt            (dec_rt),
		.ctrl          (dec_ctrl),
		.imm           (dec_imm),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	mips_regfile regfile_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.we       (wb_we),
		.w_idx    (wb_idx),
		.r_idx_a  (dec_rs),
		.r_idx_b  (dec_rt),
		.w_data   (wb_data),
		.r_data_a (rf_rs_val),
		.r_data_b (rf_rt_val)
	);

	// For jal, decode returns the link value on imm
	assign id_ex_d = '{
		ctrl:   dec_ctrl,
		rs:     dec_rs,
		rt:     dec_rt,
		rs_val: rf_rs_val,
		rt_val: rf_rt_val,
		imm:    dec_imm,
		shamt:  if_id_q.instr[10:6],
		link:   dec_imm
	};

	mips_pipe_reg #(.payload_t(mips_pkg::id_ex_t)) id_ex_i (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (1'b1),
		.clear (stall),
		.d     (id_ex_d),
		.q     (id_ex_q)
	);

	mips_execute execute_i (
		.id_ex     (id_ex_q),
		.m_fwd     (m_fwd),
		.w_fwd     (wb_data),
		.fwd_alu_a (fwd_alu_a),
		.fwd_alu_b (fwd_alu_b),
		.ex_mem    (ex_mem_d)
	);

	mips_pipe_reg #(.payload_t(mips_pkg::ex_mem_t)) ex_mem_i (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (1'b1),
		.clear (1'b0),
		.d     (ex_mem_d),
		.q     (ex_mem_q)
	);

	// Memory stage
	assign m_fwd    = (ex_mem_q.ctrl.wb_src == mips_pkg::WB_LINK) ? ex_mem_q.link :
		ex_mem_q.alu_res;
	assign dm_addr  = ex_mem_q.alu_res[31:2];
	assign dm_wdata = fwd_store ? wb_data : ex_mem_q.store_data;
	assign dm_we    = ex_mem_q.ctrl.mem_write;
	assign mem_wb_d = '{
		ctrl:     ex_mem_q.ctrl,
		alu_res:  ex_mem_q.alu_res,
		mem_data: dm_rdata,
		link:     ex_mem_q.link
	};

	mips_pipe_reg #(.payload_t(mips_pkg::mem_wb_t)) mem_wb_i (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (1'b1),
		.clear (1'b0),
		.d     (mem_wb_d),
		.q     (mem_wb_q)
	);

	// Write-back
	always_comb begin
		case (mem_wb_q.ctrl.wb_src)
			mips_pkg::WB_MEM:  wb_data = mem_wb_q.mem_data;
			mips_pkg::WB_LINK: wb_data = mem_wb_q.link;
			default:           wb_data = mem_wb_q.alu_res;
		endcase
	end

	assign wb_we  = mem_wb_q.ctrl.reg_write;
	assign wb_idx = mem_wb_q.ctrl.dest;

	mips_hazard hazard_i (
		.rs_d      (dec_rs),
		.rt_d      (dec_rt),
		.ctrl_d    (dec_ctrl),
		.id_ex     (id_ex_q),
		.ex_mem    (ex_mem_q),
		.mem_wb    (mem_wb_q),
		.stall     (stall),
		.fwd_cmp_a (fwd_cmp_a),
		.fwd_cmp_b (fwd_cmp_b),
		.fwd_alu_a (fwd_alu_a),
		.fwd_alu_b (fwd_alu_b),
		.fwd_store (fwd_store)
	);

endmodule

`default_nettype wire

// ==== mips_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_hazard (
	input  wire mips_pkg::reg_idx_t rs_d,
	input  wire mips_pkg::reg_idx_t rt_d,
	input  wire mips_pkg::ctrl_t    ctrl_d,
	input  wire mips_pkg::id_ex_t   id_ex,
	input  wire mips_pkg::ex_mem_t  ex_mem,
	input  wire mips_pkg::mem_wb_t  mem_wb,
	output logic                    stall,
	output mips_pkg::fwd_sel_t      fwd_cmp_a,
	output mips_pkg::fwd_sel_t      fwd_cmp_b,
	output mips_pkg::fwd_sel_t      fwd_alu_a,
	output mips_pkg::fwd_sel_t      fwd_alu_b,
	output logic                    fwd_store
);

	logic load_use;
	logic cmp_wait_e;
	logic cmp_wait_m;
	logic m_named;
	logic w_named;

	// Register 0 never creates a dependency
	function automatic logic writes(mips_pkg::ctrl_t c, mips_pkg::reg_idx_t r);
		return c.reg_write && r != '0 && c.dest == r;
	endfunction

	// Load data is not ready in the memory stage, only ALU and link results are
	function automatic mips_pkg::fwd_sel_t src_sel(
		mips_pkg::reg_idx_t r,
		mips_pkg::ctrl_t    m,
		mips_pkg::ctrl_t    w
	);
		if (writes(m, r) && m.wb_src != mips_pkg::WB_MEM) begin
			return mips_pkg::FWD_FROM_M;
		end
		if (writes(w, r)) begin
			return mips_pkg::FWD_FROM_W;
		end
		return mips_pkg::FWD_REG;
	endfunction

	assign fwd_cmp_a = src_sel(rs_d, ex_mem.ctrl, mem_wb.ctrl);
	assign fwd_cmp_b = src_sel(rt_d, ex_mem.ctrl, mem_wb.ctrl);
	assign fwd_alu_a = src_sel(id_ex.rs, ex_mem.ctrl, mem_wb.ctrl);
	assign fwd_alu_b = src_sel(id_ex.rt, ex_mem.ctrl, mem_wb.ctrl);

	// A store right behind a load picks the loaded word up from write-back
	assign fwd_store = ex_mem.ctrl.mem_write && writes(mem_wb.ctrl, ex_mem.ctrl.dest);

	// Store data alone does not need the load-use bubble
	assign load_use = id_ex.ctrl.mem_read && (writes(id_ex.ctrl, rs_d) ||
		(writes(id_ex.ctrl, rt_d) && !ctrl_d.mem_write));
	assign cmp_wait_e = ctrl_d.branch &&
		(writes(id_ex.ctrl, rs_d) || writes(id_ex.ctrl, rt_d));
	// Second bubble when the comparator waits on a load
	assign cmp_wait_m = ctrl_d.branch && ex_mem.ctrl.mem_read &&
		(writes(ex_mem.ctrl, rs_d) || writes(ex_mem.ctrl, rt_d));
	assign stall = load_use || cmp_wait_e || cmp_wait_m;

	assign m_named = fwd_cmp_a == mips_pkg::FWD_FROM_M || fwd_cmp_b == mips_pkg::FWD_FROM_M ||
		fwd_alu_a == mips_pkg::FWD_FROM_M || fwd_alu_b == mips_pkg::FWD_FROM_M;
	assign w_named = fwd_cmp_a == mips_pkg::FWD_FROM_W || fwd_cmp_b == mips_pkg::FWD_FROM_W ||
		fwd_alu_a == mips_pkg::FWD_FROM_W || fwd_alu_b == mips_pkg::FWD_FROM_W || fwd_store;

	always_comb begin
		fwd_m_live: assert (!m_named || ex_mem.ctrl.reg_write);
		fwd_w_live: assert (!w_named || mem_wb.ctrl.reg_write);
	end

endmodule

`default_nettype wire

// ==== mips_execute.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module mips_execute (
	input  wire mips_pkg::id_ex_t   id_ex,
	input  wire mips_pkg::word_t    m_fwd,
	input  wire mips_pkg::word_t    w_fwd,
	input  wire mips_pkg::fwd_sel_t fwd_alu_a,
	input  wire mips_pkg::fwd_sel_t fwd_alu_b,
	output mips_pkg::ex_mem_t       ex_mem
);

	mips_pkg::word_t op_a;
	mips_pkg::word_t rt_fwd;
	mips_pkg::word_t op_b;
	mips_pkg::word_t alu_res;

	assign op_a   = mips_pkg::fwd_pick(fwd_alu_a, id_ex.rs_val, m_fwd, w_fwd);
	assign rt_fwd = mips_pkg::fwd_pick(fwd_alu_b, id_ex.rt_val, m_fwd, w_fwd);
	assign op_b   = id_ex.ctrl.alu_imm ? id_ex.imm : rt_fwd;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			mips_pkg::ALU_SUB: alu_res = op_a - op_b;
			mips_pkg::ALU_AND: alu_res = op_a & op_b;
			mips_pkg::ALU_OR:  alu_res = op_a | op_b;
			mips_pkg::ALU_XOR: alu_res = op_a ^ op_b;
			mips_pkg::ALU_SLT: begin
				alu_res = {{(`MIPS_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			end
			// sll shifts rt by shamt, lui moves the immediate to the upper half
			mips_pkg::ALU_SLL: alu_res = op_b << id_ex.shamt;
			mips_pkg::ALU_LUI: alu_res = op_b << (`MIPS_XLEN / 2);
			default:           alu_res = op_a + op_b;
		endcase
	end

	assign ex_mem = '{
		ctrl:       id_ex.ctrl,
		alu_res:    alu_res,
		store_data: rt_fwd,
		link:       id_ex.link
	};

	always_comb begin
		alu_op_legal: assert (id_ex.ctrl.alu_op <= mips_pkg::ALU_LUI);
	end

endmodule

`default_nettype wire

// ==== mips_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module mips_regfile (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     we,
	input  wire mips_pkg::reg_idx_t w_idx,
	input  wire mips_pkg::reg_idx_t r_idx_a,
	input  wire mips_pkg::reg_idx_t r_idx_b,
	input  wire mips_pkg::word_t    w_data,
	output mips_pkg::word_t         r_data_a,
	output mips_pkg::word_t         r_data_b
);

	mips_pkg::word_t regs [`MIPS_NREGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MIPS_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && w_idx != '0) begin
			regs[w_idx] <= w_data;
		end
	end

	// Write-through lets decode see the value retiring this cycle
	assign r_data_a = (r_idx_a == '0) ? '0 :
		(we && r_idx_a == w_idx) ? w_data : regs[r_idx_a];
	assign r_data_b = (r_idx_b == '0) ? '0 :
		(we && r_idx_b == w_idx) ? w_data : regs[r_idx_b];

	w_idx_known: assert property (@(posedge clk) disable iff (!rst_n)
		we |-> !$isunknown(w_idx));

endmodule

`default_nettype wire

// ==== mips_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module mips_decode (
	input  wire mips_pkg::if_id_t   if_id,
	input  wire mips_pkg::word_t    rs_val,
	input  wire mips_pkg::word_t    rt_val,
	input  wire mips_pkg::word_t    m_fwd,
	input  wire mips_pkg::word_t    w_fwd,
	input  wire mips_pkg::fwd_sel_t fwd_cmp_a,
	input  wire mips_pkg::fwd_sel_t fwd_cmp_b,
	output mips_pkg::reg_idx_t      rs,
	output mips_pkg::reg_idx_t      rt,
	output mips_pkg::ctrl_t         ctrl,
	output mips_pkg::word_t         imm,
	output logic                    branch_taken,
	output mips_pkg::pc_t           branch_target
);

	logic [5:0] opcode;
	logic [5:0] funct;
	mips_pkg::reg_idx_t rs_f;
	mips_pkg::reg_idx_t rt_f;
	mips_pkg::reg_idx_t rd_f;
	mips_pkg::word_t simm;
	mips_pkg::word_t zimm;
	mips_pkg::word_t cmp_a;
	mips_pkg::word_t cmp_b;
	logic is_beq;
	logic is_bne;
	logic is_jr;
	logic is_jump;

	assign opcode = if_id.instr[31:26];
	assign funct  = if_id.instr[5:0];
	assign rs_f   = if_id.instr[25:21];
	assign rt_f   = if_id.instr[20:16];
	assign rd_f   = if_id.instr[15:11];
	assign simm   = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
	assign zimm   = {16'h0000, if_id.instr[15:0]};

	// rs and rt stay zero when not read, so the hazard unit sees no false match
	always_comb begin
		ctrl    = '0;
		rs      = '0;
		rt      = '0;
		imm     = '0;
		is_beq  = 1'b0;
		is_bne  = 1'b0;
		is_jr   = 1'b0;
		is_jump = 1'b0;
		case (opcode)
			`MIPS_OP_SPECIAL: begin
				rs             = rs_f;
				rt             = rt_f;
				ctrl.reg_write = 1'b1;
				ctrl.dest      = rd_f;
				case (funct)
					`MIPS_FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
					`MIPS_FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
					`MIPS_FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
					`MIPS_FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
					`MIPS_FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
					`MIPS_FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
					`MIPS_FN_SLL: begin
						rs          = '0;
						ctrl.alu_op = mips_pkg::ALU_SLL;
					end
					`MIPS_FN_JR: begin
						rt          = '0;
						ctrl        = '0;
						ctrl.branch = 1'b1;
						is_jr       = 1'b1;
					end
					default: begin
						rs   = '0;
						rt   = '0;
						ctrl = '0;
					end
				endcase
			end
			`MIPS_OP_ADDIU, `MIPS_OP_ORI, `MIPS_OP_LUI: begin
				rs             = (opcode == `MIPS_OP_LUI) ? '0 : rs_f;
				ctrl.alu_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.dest      = rt_f;
				imm            = (opcode == `MIPS_OP_ADDIU) ? simm : zimm;
				if (opcode == `MIPS_OP_ORI) begin
					ctrl.alu_op = mips_pkg::ALU_OR;
				end else if (opcode == `MIPS_OP_LUI) begin
					ctrl.alu_op = mips_pkg::ALU_LUI;
				end
			end
			`MIPS_OP_LW: begin
				rs             = rs_f;
				ctrl.alu_imm   = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src    = mips_pkg::WB_MEM;
				ctrl.dest      = rt_f;
				imm            = simm;
			end
			`MIPS_OP_SW: begin
				rs             = rs_f;
				rt             = rt_f;
				ctrl.alu_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
				// Data register, used by the store-data bypass in the memory stage
				ctrl.dest      = rt_f;
				imm            = simm;
			end
			`MIPS_OP_BEQ, `MIPS_OP_BNE: begin
				rs          = rs_f;
				rt          = rt_f;
				ctrl.branch = 1'b1;
				is_beq      = (opcode == `MIPS_OP_BEQ);
				is_bne      = (opcode == `MIPS_OP_BNE);
			end
			`MIPS_OP_J: is_jump = 1'b1;
			`MIPS_OP_JAL: begin
				is_jump        = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.wb_src    = mips_pkg::WB_LINK;
				// Register 31
				ctrl.dest      = '1;
				// Link goes out on imm, pointing past the delay slot
				imm            = {if_id.pc_plus4 + 1'b1, 2'b00};
			end
			default: ctrl = '0;
		endcase
	end

	assign cmp_a = mips_pkg::fwd_pick(fwd_cmp_a, rs_val, m_fwd, w_fwd);
	assign cmp_b = mips_pkg::fwd_pick(fwd_cmp_b, rt_val, m_fwd, w_fwd);

	always_comb begin
		branch_taken  = 1'b0;
		branch_target = if_id.pc_plus4 + simm[`MIPS_XLEN-3:0];
		if (is_beq) begin
			branch_taken = (cmp_a == cmp_b);
		end else if (is_bne) begin
			branch_taken = (cmp_a != cmp_b);
		end else if (is_jr) begin
			branch_taken  = 1'b1;
			branch_target = cmp_a[`MIPS_XLEN-1:2];
		end else if (is_jump) begin
			branch_taken  = 1'b1;
			branch_target = {if_id.pc_plus4[29:26], if_id.instr[25:0]};
		end
	end

endmodule

`default_nettype wire

// ==== mips_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mips_macros.svh"

module mips_fetch (
	input  wire                clk,
	input  wire                rst_n,
	input  wire                stall,
	input  wire                branch_taken,
	input  wire mips_pkg::pc_t branch_target,
	output mips_pkg::pc_t      pc,
	output mips_pkg::pc_t      pc_plus1
);

	mips_pkg::pc_t next_pc;

	assign pc_plus1 = pc + 1'b1;
	// Decode redirects after the delay slot has been fetched
	assign next_pc = branch_taken ? branch_target : pc_plus1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `MIPS_RESET_PC;
		end else if (!stall) begin
			pc <= next_pc;
		end
	end

	pc_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(pc));

endmodule

`default_nettype wire

// ==== mips_pipe_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           we,
	input  wire           clear,
	input  wire payload_t d,
	output payload_t      q
);

	// Clear wins over we and loads a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			q <= '0;
		end else if (clear) begin
			q <= '0;
		end else if (we) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== mips_pkg.sv ====
`default_nettype none
`include "mips_macros.svh"

package mips_pkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	// Word address, byte offset dropped
	typedef logic [`MIPS_XLEN-3:0] pc_t;
	typedef logic [$clog2(`MIPS_NREGS)-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_FROM_M,
		FWD_FROM_W
	} fwd_sel_t;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK
	} wb_src_t;

	// All-zero value is a bubble
	typedef struct packed {
		alu_op_t  alu_op;
		logic     alu_imm;
		logic     mem_read;
		logic     mem_write;
		logic     reg_write;
		// Reads its operands in decode (beq, bne, jr)
		logic     branch;
		wb_src_t  wb_src;
		reg_idx_t dest;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		pc_t   pc_plus4;
	} if_id_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rs;
		reg_idx_t rt;
		word_t    rs_val;
		word_t    rt_val;
		word_t    imm;
		logic [4:0] shamt;
		word_t    link;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_res;
		word_t store_data;
		word_t link;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_res;
		word_t mem_data;
		word_t link;
	} mem_wb_t;

	// Operand bypass mux shared by the comparator and the ALU
	function automatic word_t fwd_pick(
		fwd_sel_t sel,
		word_t    reg_val,
		word_t    m_val,
		word_t    w_val
	);
		case (sel)
			FWD_FROM_M: return m_val;
			FWD_FROM_W: return w_val;
			default:    return reg_val;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== mips_macros.svh ====
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

// Core sizes
`define MIPS_XLEN       32
`define MIPS_NREGS      32
// Word address of the first fetch
`define MIPS_RESET_PC   30'h0

// Primary opcodes
`define MIPS_OP_SPECIAL 6'h00
`define MIPS_OP_J       6'h02
`define MIPS_OP_JAL     6'h03
`define MIPS_OP_BEQ     6'h04
`define MIPS_OP_BNE     6'h05
`define MIPS_OP_ADDIU   6'h09
`define MIPS_OP_ORI     6'h0d
`define MIPS_OP_LUI     6'h0f
`define MIPS_OP_LW      6'h23
`define MIPS_OP_SW      6'h2b

// Funct codes under SPECIAL
`define MIPS_FN_SLL     6'h00
`define MIPS_FN_JR      6'h08
`define MIPS_FN_ADDU    6'h21
`define MIPS_FN_SUBU    6'h23
`define MIPS_FN_AND     6'h24
`define MIPS_FN_OR      6'h25
`define MIPS_FN_XOR     6'h26
`define MIPS_FN_SLT     6'h2a

`endif
